//--- hdl/lane_defines.svh
`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

// Element width in bits, one 32-bit word per element
`define ELEN 32

// Instruction identifiers that can be in flight at once
// Sizes the one-hot done vectors
`define NR_VINSN 8

// Register file address width, element addresses wrap at 2^VADDR_W
`define VADDR_W 8

// Vector length field, 1 to 15 elements per instruction
`define VL_W 4

// Operand queue depth, power of two
`define OPQ_DEPTH 4

`endif

//--- hdl/lane_pkg.sv
`include "lane_defines.svh"
`default_nettype none

package lane_pkg;

  // Opcodes understood by the lane functional units
  // ALU: add/sub/and/or/xor, multiplier: mul/macc
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL,
    OP_MACC
  } vfu_op_e;

  // Target functional unit
  typedef enum logic [0:0] {
    VFU_ALU,
    VFU_MFPU
  } vfu_e;

  // Instruction identifier, indexes the done vectors
  typedef logic [$clog2(`NR_VINSN)-1:0] vid_t;

  // Issued operation as seen by the functional units
  typedef struct packed {
    vid_t                 id;
    vfu_op_e              op;
    vfu_e                 vfu;
    // Element count, never zero
    logic [`VL_W-1:0]     vl;
    // Destination base, element i lands at vd_addr + i
    logic [`VADDR_W-1:0]  vd_addr;
  } vfu_operation_t;

  // One element write towards the register file
  typedef struct packed {
    vid_t                 id;
    logic [`VADDR_W-1:0]  addr;
    logic [`ELEN-1:0]     wdata;
  } vrf_wreq_t;

endpackage

`default_nettype wire

//--- hdl/operand_queue.sv
`include "lane_defines.svh"
`default_nettype none

module operand_queue #(
  parameter int unsigned DEPTH = `OPQ_DEPTH
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Producer side, valid/ready
  input  logic [`ELEN-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  // Consumer side, head element with pop strobe
  output logic [`ELEN-1:0] data_o,
  output logic             not_empty_o,
  input  logic             pop_i
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  // Storage, no reset needed
  logic [`ELEN-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // One extra bit so that full is distinguishable from empty
  logic [PTR_W:0]   count_q;
  logic             push;
  logic             pop;

  assign ready_o     = (count_q != (PTR_W+1)'(DEPTH));
  assign not_empty_o = (count_q != '0);
  assign push        = valid_i && ready_o;
  // Pop on empty is ignored
  assign pop         = pop_i && not_empty_o;
  assign data_o      = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap naturally since DEPTH is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      // Simultaneous push and pop keeps the fill level
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/valu.sv
`include "lane_defines.svh"
`default_nettype none

module valu (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Sequencer interface
  input  lane_pkg::vfu_operation_t operation_i,
  input  logic                     operation_valid_i,
  output logic                     ready_o,
  output logic [`NR_VINSN-1:0]     vinsn_done_o,
  // Operand queues, bit 0 is a and bit 1 is b
  input  logic [`ELEN-1:0]         operand_a_i,
  input  logic [`ELEN-1:0]         operand_b_i,
  input  logic [1:0]               operand_not_empty_i,
  output logic [1:0]               operand_pop_o,
  // Register file write port, req/gnt
  output logic                     result_req_o,
  output lane_pkg::vrf_wreq_t      result_o,
  input  logic                     result_gnt_i
);

  // EXEC pops elements, LAST drains the final write and emits done
  typedef enum logic [1:0] {IDLE, EXEC, LAST} state_e;

  state_e                   state_q;
  lane_pkg::vfu_operation_t op_q;
  logic [`VL_W-1:0]         elem_cnt_q;
  logic                     result_req_q;
  lane_pkg::vrf_wreq_t      result_q;
  logic [`NR_VINSN-1:0]     done_q;
  logic                     accept;
  logic                     out_free;
  logic                     pop;
  logic [`ELEN-1:0]         alu_res;

  assign ready_o  = (state_q == IDLE);
  assign accept   = operation_valid_i && ready_o;
  // Output register frees up when empty or granted this cycle
  assign out_free = !result_req_q || result_gnt_i;
  // Both queues pop together, only once both hold data
  assign pop           = (state_q == EXEC) && (&operand_not_empty_i) && out_free;
  assign operand_pop_o = {pop, pop};

  always_comb begin
    case (op_q.op)
      lane_pkg::OP_ADD: alu_res = operand_a_i + operand_b_i;
      lane_pkg::OP_SUB: alu_res = operand_a_i - operand_b_i;
      lane_pkg::OP_AND: alu_res = operand_a_i & operand_b_i;
      lane_pkg::OP_OR:  alu_res = operand_a_i | operand_b_i;
      lane_pkg::OP_XOR: alu_res = operand_a_i ^ operand_b_i;
      // Multiplier opcodes never get steered here
      default:          alu_res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= IDLE;
      elem_cnt_q   <= '0;
      result_req_q <= 1'b0;
      done_q       <= '0;
    end else begin
      // Done is a single cycle pulse
      done_q <= '0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q    <= EXEC;
            elem_cnt_q <= '0;
          end
        end
        EXEC: begin
          if (pop) begin
            elem_cnt_q <= elem_cnt_q + `VL_W'(1);
            // Last element popped, nothing left to fetch
            if (elem_cnt_q == op_q.vl - `VL_W'(1)) state_q <= LAST;
          end
        end
        LAST: begin
          // Only the final element can still be pending here
          if (|done_q) state_q <= IDLE;
          else if (result_req_q && result_gnt_i) done_q[op_q.id] <= 1'b1;
        end
        default: state_q <= IDLE;
      endcase
      // New element takes priority over retiring the old one
      if (pop) result_req_q <= 1'b1;
      else if (result_gnt_i) result_req_q <= 1'b0;
    end
  end

  // Instruction latch and result payload
  always_ff @(posedge clk_i) begin
    if (accept) op_q <= operation_i;
    if (pop) begin
      result_q.id    <= op_q.id;
      result_q.addr  <= op_q.vd_addr + `VADDR_W'(elem_cnt_q);
      result_q.wdata <= alu_res;
    end
  end

  assign result_req_o = result_req_q;
  assign result_o     = result_q;
  assign vinsn_done_o = done_q;

endmodule

`default_nettype wire

//--- hdl/vmfpu.sv
`include "lane_defines.svh"
`default_nettype none

module vmfpu (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Sequencer interface
  input  lane_pkg::vfu_operation_t operation_i,
  input  logic                     operation_valid_i,
  output logic                     ready_o,
  output logic [`NR_VINSN-1:0]     vinsn_done_o,
  // Operand queues, bits 0/1/2 are a/b/c
  input  logic [`ELEN-1:0]         operand_a_i,
  input  logic [`ELEN-1:0]         operand_b_i,
  input  logic [`ELEN-1:0]         operand_c_i,
  input  logic [2:0]               operand_not_empty_i,
  output logic [2:0]               operand_pop_o,
  // Register file write port, req/gnt
  output logic                     result_req_o,
  output lane_pkg::vrf_wreq_t      result_o,
  input  logic                     result_gnt_i
);

  logic                     busy_q;
  lane_pkg::vfu_operation_t op_q;
  // Elements popped and elements written back
  logic [`VL_W-1:0]         issue_cnt_q;
  logic [`VL_W-1:0]         retire_cnt_q;
  // Stage 1, low half of the product plus c and address
  logic                     s1_valid_q;
  logic [`ELEN-1:0]         s1_prod_q;
  logic [`ELEN-1:0]         s1_c_q;
  logic [`VADDR_W-1:0]      s1_addr_q;
  // Stage 2, doubles as the output register
  logic                     s2_valid_q;
  lane_pkg::vrf_wreq_t      s2_q;
  logic [`NR_VINSN-1:0]     done_q;
  logic                     accept;
  logic                     is_macc;
  logic [2:0]               need;
  logic                     stall;
  logic                     fire;
  logic                     retire;
  logic [2*`ELEN-1:0]       prod_full;

  // Idle only once every element of the last instruction is written
  assign ready_o   = !busy_q;
  assign accept    = operation_valid_i && ready_o;
  assign is_macc   = (op_q.op == lane_pkg::OP_MACC);
  // Queue c only matters for multiply-accumulate
  assign need      = {is_macc, 2'b11};
  // Held output without grant freezes both stages
  assign stall     = s2_valid_q && !result_gnt_i;
  assign fire      = busy_q && (issue_cnt_q != op_q.vl) && !stall &&
                     ((operand_not_empty_i & need) == need);
  assign operand_pop_o = need & {3{fire}};
  assign retire    = s2_valid_q && result_gnt_i;
  assign prod_full = operand_a_i * operand_b_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      issue_cnt_q  <= '0;
      retire_cnt_q <= '0;
      s1_valid_q   <= 1'b0;
      s2_valid_q   <= 1'b0;
      done_q       <= '0;
    end else begin
      done_q <= '0;
      if (accept) begin
        busy_q       <= 1'b1;
        issue_cnt_q  <= '0;
        retire_cnt_q <= '0;
      end else if (|done_q) begin
        busy_q <= 1'b0;
      end
      if (fire) issue_cnt_q <= issue_cnt_q + `VL_W'(1);
      if (retire) begin
        retire_cnt_q <= retire_cnt_q + `VL_W'(1);
        // Final element granted, pulse this id next cycle
        if (retire_cnt_q == op_q.vl - `VL_W'(1)) done_q[op_q.id] <= 1'b1;
      end
      // Valid bits advance together unless stalled
      if (!stall) begin
        s1_valid_q <= fire;
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) op_q <= operation_i;
    if (!stall) begin
      if (fire) begin
        // Low 32 bits only, wrap-around
        s1_prod_q <= prod_full[`ELEN-1:0];
        s1_c_q    <= operand_c_i;
        s1_addr_q <= op_q.vd_addr + `VADDR_W'(issue_cnt_q);
      end
      if (s1_valid_q) begin
        s2_q.id    <= op_q.id;
        s2_q.addr  <= s1_addr_q;
        s2_q.wdata <= is_macc ? s1_prod_q + s1_c_q : s1_prod_q;
      end
    end
  end

  assign result_req_o = s2_valid_q;
  assign result_o     = s2_q;
  assign vinsn_done_o = done_q;

endmodule

`default_nettype wire

//--- hdl/vector_fus_stage.sv
`include "lane_defines.svh"
`default_nettype none

module vector_fus_stage (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Sequencer interface
  input  lane_pkg::vfu_operation_t      vfu_operation_i,
  input  logic                          vfu_operation_valid_i,
  output logic                          alu_ready_o,
  output logic                          mfpu_ready_o,
  output logic [`NR_VINSN-1:0]          alu_vinsn_done_o,
  output logic [`NR_VINSN-1:0]          mfpu_vinsn_done_o,
  // Operand queue heads
  input  logic [1:0][`ELEN-1:0]         alu_operand_i,
  input  logic [1:0]                    alu_operand_not_empty_i,
  output logic [1:0]                    alu_operand_pop_o,
  input  logic [2:0][`ELEN-1:0]         mfpu_operand_i,
  input  logic [2:0]                    mfpu_operand_not_empty_i,
  output logic [2:0]                    mfpu_operand_pop_o,
  // Register file write ports
  output logic                          alu_result_req_o,
  output lane_pkg::vrf_wreq_t           alu_result_o,
  input  logic                          alu_result_gnt_i,
  output logic                          mfpu_result_req_o,
  output lane_pkg::vrf_wreq_t           mfpu_result_o,
  input  logic                          mfpu_result_gnt_i
);

  logic alu_valid;
  logic mfpu_valid;

  // Unit select decoded once here, units just see their own valid
  assign alu_valid  = vfu_operation_valid_i && (vfu_operation_i.vfu == lane_pkg::VFU_ALU);
  assign mfpu_valid = vfu_operation_valid_i && (vfu_operation_i.vfu == lane_pkg::VFU_MFPU);

  valu u_valu (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .operation_i         (vfu_operation_i),
    .operation_valid_i   (alu_valid),
    .ready_o             (alu_ready_o),
    .vinsn_done_o        (alu_vinsn_done_o),
    .operand_a_i         (alu_operand_i[0]),
    .operand_b_i         (alu_operand_i[1]),
    .operand_not_empty_i (alu_operand_not_empty_i),
    .operand_pop_o       (alu_operand_pop_o),
    .result_req_o        (alu_result_req_o),
    .result_o            (alu_result_o),
    .result_gnt_i        (alu_result_gnt_i)
  );

  vmfpu u_vmfpu (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .operation_i         (vfu_operation_i),
    .operation_valid_i   (mfpu_valid),
    .ready_o             (mfpu_ready_o),
    .vinsn_done_o        (mfpu_vinsn_done_o),
    .operand_a_i         (mfpu_operand_i[0]),
    .operand_b_i         (mfpu_operand_i[1]),
    .operand_c_i         (mfpu_operand_i[2]),
    .operand_not_empty_i (mfpu_operand_not_empty_i),
    .operand_pop_o       (mfpu_operand_pop_o),
    .result_req_o        (mfpu_result_req_o),
    .result_o            (mfpu_result_o),
    .result_gnt_i        (mfpu_result_gnt_i)
  );

endmodule

`default_nettype wire

//--- hdl/lane_exec.sv
`include "lane_defines.svh"
`default_nettype none

module lane_exec (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Lane sequencer
  input  lane_pkg::vfu_operation_t      vfu_operation_i,
  input  logic                          vfu_operation_valid_i,
  output logic                          alu_ready_o,
  output logic                          mfpu_ready_o,
  output logic [`NR_VINSN-1:0]          alu_vinsn_done_o,
  output logic [`NR_VINSN-1:0]          mfpu_vinsn_done_o,
  // Operand streams, valid/ready per queue
  input  logic [1:0][`ELEN-1:0]         alu_operand_i,
  input  logic [1:0]                    alu_operand_valid_i,
  output logic [1:0]                    alu_operand_ready_o,
  input  logic [2:0][`ELEN-1:0]         mfpu_operand_i,
  input  logic [2:0]                    mfpu_operand_valid_i,
  output logic [2:0]                    mfpu_operand_ready_o,
  // Register file write ports
  output logic                          alu_result_req_o,
  output lane_pkg::vrf_wreq_t           alu_result_o,
  input  logic                          alu_result_gnt_i,
  output logic                          mfpu_result_req_o,
  output lane_pkg::vrf_wreq_t           mfpu_result_o,
  input  logic                          mfpu_result_gnt_i
);

  // Queue heads towards the units
  logic [1:0][`ELEN-1:0] alu_opq_data;
  logic [1:0]            alu_opq_not_empty;
  logic [1:0]            alu_opq_pop;
  logic [2:0][`ELEN-1:0] mfpu_opq_data;
  logic [2:0]            mfpu_opq_not_empty;
  logic [2:0]            mfpu_opq_pop;

  // ALU operands a and b
  for (genvar i = 0; i < 2; i++) begin : gen_alu_opq
    operand_queue #(.DEPTH(`OPQ_DEPTH)) u_opq (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .data_i      (alu_operand_i[i]),
      .valid_i     (alu_operand_valid_i[i]),
      .ready_o     (alu_operand_ready_o[i]),
      .data_o      (alu_opq_data[i]),
      .not_empty_o (alu_opq_not_empty[i]),
      .pop_i       (alu_opq_pop[i])
    );
  end

  // Multiplier operands a, b and accumulator c
  for (genvar i = 0; i < 3; i++) begin : gen_mfpu_opq
    operand_queue #(.DEPTH(`OPQ_DEPTH)) u_opq (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .data_i      (mfpu_operand_i[i]),
      .valid_i     (mfpu_operand_valid_i[i]),
      .ready_o     (mfpu_operand_ready_o[i]),
      .data_o      (mfpu_opq_data[i]),
      .not_empty_o (mfpu_opq_not_empty[i]),
      .pop_i       (mfpu_opq_pop[i])
    );
  end

  vector_fus_stage u_vector_fus_stage (
    .clk_i                    (clk_i),
    .rst_n_i                  (rst_n_i),
    .vfu_operation_i          (vfu_operation_i),
    .vfu_operation_valid_i    (vfu_operation_valid_i),
    .alu_ready_o              (alu_ready_o),
    .mfpu_ready_o             (mfpu_ready_o),
    .alu_vinsn_done_o         (alu_vinsn_done_o),
    .mfpu_vinsn_done_o        (mfpu_vinsn_done_o),
    .alu_operand_i            (alu_opq_data),
    .alu_operand_not_empty_i  (alu_opq_not_empty),
    .alu_operand_pop_o        (alu_opq_pop),
    .mfpu_operand_i           (mfpu_opq_data),
    .mfpu_operand_not_empty_i (mfpu_opq_not_empty),
    .mfpu_operand_pop_o       (mfpu_opq_pop),
    .alu_result_req_o         (alu_result_req_o),
    .alu_result_o             (alu_result_o),
    .alu_result_gnt_i         (alu_result_gnt_i),
    .mfpu_result_req_o        (mfpu_result_req_o),
    .mfpu_result_o            (mfpu_result_o),
    .mfpu_result_gnt_i        (mfpu_result_gnt_i)
  );

endmodule

`default_nettype wire

//--- sim/tb_lane_exec.sv
`include "lane_defines.svh"
`default_nettype none

module tb_lane_exec;
  timeunit 1ns;
  timeprecision 1ps;

  // Run limit, the directed tests need about 1000 cycles
  localparam int MAX_CYCLES = 4000;

  logic                          clk;
  logic                          rst_n;
  lane_pkg::vfu_operation_t      vfu_operation_i;
  logic                          vfu_operation_valid_i;
  logic                          alu_ready_o;
  logic                          mfpu_ready_o;
  logic [`NR_VINSN-1:0]          alu_vinsn_done_o;
  logic [`NR_VINSN-1:0]          mfpu_vinsn_done_o;
  logic [1:0][`ELEN-1:0]         alu_operand_i;
  logic [1:0]                    alu_operand_valid_i;
  logic [1:0]                    alu_operand_ready_o;
  logic [2:0][`ELEN-1:0]         mfpu_operand_i;
  logic [2:0]                    mfpu_operand_valid_i;
  logic [2:0]                    mfpu_operand_ready_o;
  logic                          alu_result_req_o;
  lane_pkg::vrf_wreq_t           alu_result_o;
  logic                          alu_result_gnt_i;
  logic                          mfpu_result_req_o;
  lane_pkg::vrf_wreq_t           mfpu_result_o;
  logic                          mfpu_result_gnt_i;

  // Operand streams 0/1 feed ALU a/b, 2/3/4 feed multiplier a/b/c
  logic [`ELEN-1:0]              stim_q [5][$];
  // Expected writes per unit, 0 is the ALU and 1 the multiplier
  lane_pkg::vrf_wreq_t           exp_q [2][$];
  lane_pkg::vfu_operation_t      issue_q [$];
  // Accumulator values pushed but not yet used by a MACC
  logic [`ELEN-1:0]              c_model_q [$];
  logic [31:0]                   lfsr_state;
  logic [1:0]                    gnt_lfsr;
  logic                          overlap_seen;
  int                            next_id;
  int                            errors;
  int                            cycle_cnt;

  lane_exec u_lane_exec (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .*
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
    return out;
  endfunction

  function automatic logic [`ELEN-1:0] rand_word();
    logic [`ELEN-1:0] w;
    for (int i = 0; i < `ELEN; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  // Reference for every opcode, everything wraps at 2^32
  function automatic logic [`ELEN-1:0] model_result(input lane_pkg::vfu_op_e op,
      input logic [`ELEN-1:0] a, input logic [`ELEN-1:0] b, input logic [`ELEN-1:0] c);
    case (op)
      lane_pkg::OP_ADD:  return a + b;
      lane_pkg::OP_SUB:  return a - b;
      lane_pkg::OP_AND:  return a & b;
      lane_pkg::OP_OR:   return a | b;
      lane_pkg::OP_XOR:  return a ^ b;
      lane_pkg::OP_MUL:  return a * b;
      lane_pkg::OP_MACC: return a * b + c;
      default:           return '0;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Builds an operation, queues it for issue and returns its id
  function automatic lane_pkg::vid_t queue_insn(input lane_pkg::vfu_op_e op,
      input lane_pkg::vfu_e vfu, input int vl, input logic [`VADDR_W-1:0] vd);
    lane_pkg::vfu_operation_t insn;
    insn.id      = lane_pkg::vid_t'(next_id);
    insn.op      = op;
    insn.vfu     = vfu;
    insn.vl      = `VL_W'(vl);
    insn.vd_addr = vd;
    next_id = (next_id + 1) % `NR_VINSN;
    issue_q.push_back(insn);
    return insn.id;
  endfunction

  task automatic add_alu_insn(input lane_pkg::vfu_op_e op, input int vl,
      input logic [`VADDR_W-1:0] vd);
    lane_pkg::vid_t   id;
    logic [`ELEN-1:0] a;
    logic [`ELEN-1:0] b;
    id = queue_insn(op, lane_pkg::VFU_ALU, vl, vd);
    for (int i = 0; i < vl; i++) begin
      a = rand_word();
      b = rand_word();
      stim_q[0].push_back(a);
      stim_q[1].push_back(b);
      // Element i lands at vd + i, wrapping in the register file
      exp_q[0].push_back({id, vd + `VADDR_W'(i), model_result(op, a, b, '0)});
    end
  endtask

  // nc accumulator values go to queue c, whatever the opcode
  task automatic add_mfpu_insn(input lane_pkg::vfu_op_e op, input int vl,
      input logic [`VADDR_W-1:0] vd, input int nc);
    lane_pkg::vid_t   id;
    logic [`ELEN-1:0] a;
    logic [`ELEN-1:0] b;
    logic [`ELEN-1:0] c;
    id = queue_insn(op, lane_pkg::VFU_MFPU, vl, vd);
    for (int i = 0; i < nc; i++) begin
      c = rand_word();
      stim_q[4].push_back(c);
      c_model_q.push_back(c);
    end
    for (int i = 0; i < vl; i++) begin
      a = rand_word();
      b = rand_word();
      c = '0;
      // Only MACC consumes queue c
      if (op == lane_pkg::OP_MACC) begin
        c = c_model_q.pop_front();
      end
      stim_q[2].push_back(a);
      stim_q[3].push_back(b);
      exp_q[1].push_back({id, vd + `VADDR_W'(i), model_result(op, a, b, c)});
    end
  endtask

  // Runs all queued traffic to completion
  // Samples at the falling edge, drives at the rising edge
  task automatic run_traffic(input int issue_delay, input bit expect_full);
    int                      cyc;
    int                      pending;
    int                      left [2];
    lane_pkg::vid_t          cur_id [2];
    logic [1:0]              busy;
    logic [1:0]              done_due;
    logic [1:0]              after_done;
    logic [4:0]              opd_valid;
    logic [4:0]              opd_ready;
    logic [1:0]              req;
    logic [1:0]              gnt;
    logic [1:0]              rdy;
    lane_pkg::vrf_wreq_t     res [2];
    logic [`NR_VINSN-1:0]    done [2];
    logic [`NR_VINSN-1:0]    exp_done;
    lane_pkg::vrf_wreq_t     wr;
    logic [4:0]              nv;
    logic [4:0][`ELEN-1:0]   nd;
    string                   uname;
    cyc        = 0;
    busy       = '0;
    done_due   = '0;
    after_done = '0;
    do begin
      @(negedge clk);
      opd_valid = {mfpu_operand_valid_i, alu_operand_valid_i};
      opd_ready = {mfpu_operand_ready_o, alu_operand_ready_o};
      req       = {mfpu_result_req_o, alu_result_req_o};
      gnt       = {mfpu_result_gnt_i, alu_result_gnt_i};
      rdy       = {mfpu_ready_o, alu_ready_o};
      res[0]    = alu_result_o;
      res[1]    = mfpu_result_o;
      done[0]   = alu_vinsn_done_o;
      done[1]   = mfpu_vinsn_done_o;
      // Nothing issued yet, so every queue must be full by now
      if (expect_full && cyc == issue_delay) begin
        compare_value("alu_operand_ready_o", alu_operand_ready_o, 2'b00);
        compare_value("mfpu_operand_ready_o", mfpu_operand_ready_o, 3'b000);
      end
      if (&busy) begin
        overlap_seen = 1'b1;
      end
      for (int u = 0; u < 2; u++) begin
        uname = (u == 0) ? "alu" : "mfpu";
        // Ready low from acceptance through the done cycle, high right after
        if (busy[u]) begin
          compare_value({uname, "_ready_o"}, rdy[u], 1'b0);
        end
        if (after_done[u]) begin
          compare_value({uname, "_ready_o"}, rdy[u], 1'b1);
        end
        after_done[u] = 1'b0;
        exp_done = done_due[u] ? (`NR_VINSN'(1) << cur_id[u]) : '0;
        assert (!done_due[u] || done[u] != '0) else begin
          $display("ERROR: %s unit gave no done pulse after the last write of id %0d",
                   uname, cur_id[u]);
          errors++;
        end
        if (!done_due[u] || done[u] != '0) begin
          compare_value({uname, "_vinsn_done_o"}, done[u], exp_done);
        end
        if (done_due[u]) begin
          busy[u]       = 1'b0;
          done_due[u]   = 1'b0;
          after_done[u] = 1'b1;
        end
        // A write completes on this coming edge
        if (req[u] && gnt[u]) begin
          assert (exp_q[u].size() != 0) else begin
            $display("ERROR: %s unit wrote a result that no instruction expects", uname);
            errors++;
          end
          if (exp_q[u].size() != 0) begin
            wr = exp_q[u].pop_front();
            compare_value({uname, "_result_o.id"}, res[u].id, wr.id);
            compare_value({uname, "_result_o.addr"}, res[u].addr, wr.addr);
            compare_value({uname, "_result_o.wdata"}, res[u].wdata, wr.wdata);
            left[u]--;
            if (left[u] == 0) begin
              done_due[u] = 1'b1;
            end
          end
        end
      end
      // Issue handshake
      if (vfu_operation_valid_i && rdy[vfu_operation_i.vfu]) begin
        busy[vfu_operation_i.vfu]   = 1'b1;
        cur_id[vfu_operation_i.vfu] = vfu_operation_i.id;
        left[vfu_operation_i.vfu]   = int'(vfu_operation_i.vl);
        void'(issue_q.pop_front());
      end
      // Operand pushes
      for (int k = 0; k < 5; k++) begin
        if (opd_valid[k] && opd_ready[k]) begin
          void'(stim_q[k].pop_front());
        end
      end
      pending = issue_q.size() + exp_q[0].size() + exp_q[1].size();
      for (int k = 0; k < 5; k++) begin
        nv[k] = (stim_q[k].size() != 0);
        nd[k] = '0;
        if (nv[k]) begin
          nd[k] = stim_q[k][0];
        end
        pending += stim_q[k].size();
      end
      @(posedge clk);
      alu_operand_valid_i   <= nv[1:0];
      alu_operand_i         <= nd[1:0];
      mfpu_operand_valid_i  <= nv[4:2];
      mfpu_operand_i        <= nd[4:2];
      vfu_operation_valid_i <= (issue_q.size() != 0) && (cyc >= issue_delay);
      if (issue_q.size() != 0) begin
        vfu_operation_i <= issue_q[0];
      end
      alu_result_gnt_i  <= gnt_lfsr[0] ? lfsr_bit() : 1'b1;
      mfpu_result_gnt_i <= gnt_lfsr[1] ? lfsr_bit() : 1'b1;
      cyc++;
    end while (pending != 0 || busy != '0 || done_due != '0 || after_done != '0);
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    compare_value("alu_ready_o", alu_ready_o, 1'b1);
    compare_value("mfpu_ready_o", mfpu_ready_o, 1'b1);
    compare_value("alu_result_req_o", alu_result_req_o, 1'b0);
    compare_value("mfpu_result_req_o", mfpu_result_req_o, 1'b0);
    compare_value("alu_vinsn_done_o", alu_vinsn_done_o, '0);
    compare_value("mfpu_vinsn_done_o", mfpu_vinsn_done_o, '0);
    // Empty queues report not full
    compare_value("alu_operand_ready_o", alu_operand_ready_o, 2'b11);
    compare_value("mfpu_operand_ready_o", mfpu_operand_ready_o, 3'b111);
  endtask

  task automatic test_alu_opcodes();
    int vls [3] = '{1, 5, 15};
    gnt_lfsr = 2'b00;
    for (int o = 0; o < 5; o++) begin
      for (int v = 0; v < 3; v++) begin
        // Base near the top so the long vectors wrap
        add_alu_insn(lane_pkg::vfu_op_e'(o), vls[v], `VADDR_W'(8'hf0 + o));
      end
    end
    run_traffic(0, 1'b0);
  endtask

  // MUL leaves queue c alone, the next MACC picks up those values
  task automatic test_mul_macc();
    gnt_lfsr = 2'b00;
    add_mfpu_insn(lane_pkg::OP_MUL, 5, 8'h10, 3);
    run_traffic(0, 1'b0);
    add_mfpu_insn(lane_pkg::OP_MACC, 5, 8'h20, 2);
    add_mfpu_insn(lane_pkg::OP_MUL, 15, 8'hf8, 0);
    add_mfpu_insn(lane_pkg::OP_MACC, 1, 8'h30, 1);
    run_traffic(0, 1'b0);
  endtask

  task automatic test_backpressure();
    gnt_lfsr = 2'b11;
    add_alu_insn(lane_pkg::OP_SUB, 12, 8'h40);
    add_mfpu_insn(lane_pkg::OP_MACC, 9, 8'h80, 9);
    run_traffic(10, 1'b1);
  endtask

  task automatic test_concurrent();
    gnt_lfsr     = 2'b10;
    overlap_seen = 1'b0;
    add_alu_insn(lane_pkg::OP_XOR, 15, 8'h00);
    add_mfpu_insn(lane_pkg::OP_MUL, 10, 8'h60, 0);
    run_traffic(0, 1'b0);
    assert (overlap_seen) else begin
      $display("ERROR: ALU and multiplier instructions never ran at the same time");
      errors++;
    end
  endtask

  initial begin
    errors                = 0;
    next_id               = 0;
    lfsr_state            = 32'h3a5e_01ed;
    gnt_lfsr              = 2'b00;
    overlap_seen          = 1'b0;
    rst_n                 = 1'b0;
    vfu_operation_i       = '0;
    vfu_operation_valid_i = 1'b0;
    alu_operand_i         = '0;
    alu_operand_valid_i   = '0;
    mfpu_operand_i        = '0;
    mfpu_operand_valid_i  = '0;
    alu_result_gnt_i      = 1'b0;
    mfpu_result_gnt_i     = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    test_alu_opcodes();
    test_mul_macc();
    test_backpressure();
    test_concurrent();
    repeat (2) @(posedge clk);
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog in case a handshake never completes
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: run stopped after %0d cycles, the DUT stopped responding", MAX_CYCLES);
    $display("Summary: %0d errors", errors + 1);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/lane_pkg.sv
hdl/operand_queue.sv
hdl/valu.sv
hdl/vmfpu.sv
hdl/vector_fus_stage.sv
hdl/lane_exec.sv
sim/tb_lane_exec.sv

//--- run.sh
#!/bin/sh
# Compile and run the lane_exec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_lane_exec -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_lane_exec)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
